//--- Makefile
TOP = operator_control_tb

.PHONY: all build lint clean

all: build
	-./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log || ! grep -q "TEST OK" sim.log; then \
		echo "simulation failed"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

build:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- flist.f
+incdir+include
verilog/opl_ctrl_pkg.sv
verilog/slot_registers.sv
verilog/slot_sequencer.sv
verilog/phase_generator.sv
verilog/modulation_router.sv
verilog/operator_output.sv
verilog/operator_control.sv
tests/tb_clock.sv
tests/operator_control_sva.sv
tests/operator_control_tb.sv

//--- include/opl_ctrl_defs.svh
// issue-to-output latency and issue spacing; must match the phase_generator stages and sequencer states
`ifndef OPL_CTRL_DEFS_SVH
`define OPL_CTRL_DEFS_SVH

localparam int PIPE_DEPTH  = 3; // cycles from issue to valid output
localparam int SLOT_PERIOD = 2; // cycles between issues

`endif

//--- tests/operator_control_sva.sv
// timing checks for the default two-bank build; output values are checked by the testbench
`timescale 1ns/100ps

module operator_control_sva
    import opl_ctrl_pkg::*;
(
    input logic                clk,
    input logic                reset,
    input logic                issue,
    input logic [BANK_W-1:0]   issue_bank,
    input logic [OP_NUM_W-1:0] issue_op_num,
    input logic                op_out_valid,
    input logic [BANK_W-1:0]   op_out_bank,
    input logic [OP_NUM_W-1:0] op_out_op_num,
    input logic                ops_done_pulse
);
    int   failures = 0; // read by the testbench
    logic last_issue;
    logic last_out;

    assign last_issue = issue_bank == BANK_W'(NUM_BANKS - 1)
                        && issue_op_num == OP_NUM_W'(NUM_OPS_PER_BANK - 1);
    assign last_out   = op_out_valid && op_out_bank == BANK_W'(NUM_BANKS - 1)
                        && op_out_op_num == OP_NUM_W'(NUM_OPS_PER_BANK - 1);

    issue_one_cycle: assert property (@(posedge clk) disable iff (reset) issue |=> !issue)
        else begin failures++; $error("issue strobe held longer than one cycle"); end

    issue_spacing: assert property (@(posedge clk) disable iff (reset)
        issue && !last_issue |-> ##SLOT_PERIOD issue)
        else begin failures++; $error("next issue not SLOT_PERIOD cycles later"); end

    valid_after_issue: assert property (@(posedge clk) disable iff (reset)
        issue |-> ##PIPE_DEPTH op_out_valid)
        else begin failures++; $error("no valid record PIPE_DEPTH cycles after issue"); end

    valid_needs_issue: assert property (@(posedge clk) disable iff (reset)
        op_out_valid |-> $past(issue, PIPE_DEPTH))
        else begin failures++; $error("valid record without a matching issue"); end

    done_after_last: assert property (@(posedge clk) disable iff (reset)
        last_out |=> ops_done_pulse)
        else begin failures++; $error("ops_done_pulse missing after the last slot"); end

    done_only_after_last: assert property (@(posedge clk) disable iff (reset)
        ops_done_pulse |-> $past(last_out))
        else begin failures++; $error("ops_done_pulse without a last-slot record"); end

endmodule

//--- tests/operator_control_tb.sv
// default two-bank build only; register writes happen only between passes so the model stays in step
`timescale 1ns/100ps

module operator_control_tb
    import opl_ctrl_pkg::*;
;
    localparam int TIMEOUT_CYCLES = 24 * 80 + 2000; // 24 passes plus register writes
    localparam int PHASE_MASK     = (1 << PHASE_W) - 1;
    localparam int MULT_TWICE [16] = '{1, 2, 4, 6, 8, 10, 12, 14, 16, 18, 20, 20, 24, 24, 30, 30};

    logic                  clk;
    logic                  reset;
    logic                  sample_clk_en;
    logic                  reg_wr_valid;
    logic [BANK_W-1:0]     reg_wr_bank;
    logic [REG_ADDR_W-1:0] reg_wr_address;
    logic [REG_DATA_W-1:0] reg_wr_data;
    logic                  op_out_valid;
    logic [BANK_W-1:0]     op_out_bank;
    logic [OP_NUM_W-1:0]   op_out_op_num;
    op_out_t               op_out_value;
    logic                  ops_done_pulse;

    // model of the register file, phases and modulator store
    int      mult_m  [NUM_BANKS][NUM_OPS_PER_BANK];
    int      fnum_m  [NUM_BANKS][NUM_CHANNELS_PER_BANK];
    int      block_m [NUM_BANKS][NUM_CHANNELS_PER_BANK];
    int      kon_m   [NUM_BANKS][NUM_CHANNELS_PER_BANK];
    int      cnt_m   [NUM_BANKS][NUM_CHANNELS_PER_BANK];
    op_out_t mod_m   [NUM_BANKS][NUM_CHANNELS_PER_BANK];
    int      model_phase [NUM_SLOTS];

    int      exp_idx     = 0;
    int      rec_count   = 0;
    int      done_count  = 0;
    int      passes_run  = 0;
    int      cycle_count = 0;
    logic    prev_final  = 1'b0;
    op_out_t exp_val;

    tb_clock #(.PERIOD_NS(8.0)) u_clock (.clk(clk));

    operator_control #(.NUM_BANKS(NUM_BANKS), .PHASE_W(PHASE_W)) UUT (
        .clk, .reset, .sample_clk_en, .reg_wr_valid, .reg_wr_bank, .reg_wr_address,
        .reg_wr_data, .op_out_valid, .op_out_bank, .op_out_op_num, .op_out_value,
        .ops_done_pulse
    );

    bind operator_control operator_control_sva u_sva (
        .clk, .reset, .issue, .issue_bank, .issue_op_num,
        .op_out_valid, .op_out_bank, .op_out_op_num, .ops_done_pulse
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_slot(input logic [BANK_W-1:0] bank, input logic [OP_NUM_W-1:0] op,
                              input logic [BANK_W-1:0] exp_bank,
                              input logic [OP_NUM_W-1:0] exp_op);
        if (bank !== exp_bank || op !== exp_op)
            fail_run($sformatf("Mismatch at %0t: op_out_bank/op_out_op_num got %0d/%0d expected %0d/%0d",
                               $time, bank, op, exp_bank, exp_op));
    endtask

    task automatic check_value(input op_out_t got, input op_out_t exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch at %0t: op_out_value got %0d expected %0d",
                               $time, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            fail_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    // output rule applied to one slot, updating the model phase and modulator store
    function automatic op_out_t expected_value(input int bank, input int op);
        int      ch;
        int      slot;
        int      inc;
        op_out_t mod;
        op_out_t val;
        ch   = (op / 6) * 3 + op % 3;
        slot = bank * NUM_OPS_PER_BANK + op;
        if (kon_m[bank][ch] == 0) begin
            model_phase[slot] = 0; // key-off restarts the phase
            val = '0;
        end else begin
            inc = ((fnum_m[bank][ch] << block_m[bank][ch]) * MULT_TWICE[mult_m[bank][op]]) >> 2;
            model_phase[slot] = (model_phase[slot] + inc) & PHASE_MASK;
            mod = (op % 6 >= 3 && cnt_m[bank][ch] == 0) ? mod_m[bank][ch] : '0;
            val = op_out_t'(model_phase[slot] >> (PHASE_W - OP_OUT_W)) + mod;
        end
        if (op % 6 < 3)
            mod_m[bank][ch] = val; // modulator result for this pass
        return val;
    endfunction

    task automatic reg_write(input int bank, input int addr, input int data);
        @(posedge clk);
        reg_wr_valid   <= 1'b1;
        reg_wr_bank    <= BANK_W'(bank);
        reg_wr_address <= REG_ADDR_W'(addr);
        reg_wr_data    <= REG_DATA_W'(data);
        @(posedge clk);
        reg_wr_valid <= 1'b0;
    endtask

    task automatic set_mult(input int bank, input int op, input int m);
        reg_write(bank, 'h20 + (op / 6) * 8 + op % 6, m);
        mult_m[bank][op] = m;
    endtask

    task automatic set_freq(input int bank, input int ch, input int fnum, input int block,
                            input int kon);
        reg_write(bank, 'hA0 + ch, fnum & 'hff);
        reg_write(bank, 'hB0 + ch, (kon << 5) | (block << 2) | (fnum >> 8));
        fnum_m[bank][ch]  = fnum;
        block_m[bank][ch] = block;
        kon_m[bank][ch]   = kon;
    endtask

    task automatic set_cnt(input int bank, input int ch, input int c);
        reg_write(bank, 'hC0 + ch, c);
        cnt_m[bank][ch] = c;
    endtask

    task automatic randomize_voices();
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int op = 0; op < NUM_OPS_PER_BANK; op++)
                set_mult(b, op, $urandom % 16);
            for (int ch = 0; ch < NUM_CHANNELS_PER_BANK; ch++)
                set_freq(b, ch, $urandom % 1024, $urandom % 8, 1);
        end
    endtask

    // one sample_clk_en pulse, optionally a second one mid-pass, then wait for the done pulse
    task automatic run_pass(input bit mid_pulse);
        int done_start;
        int rec_start;
        done_start = done_count;
        rec_start  = rec_count;
        @(posedge clk);
        sample_clk_en <= 1'b1;
        @(posedge clk);
        sample_clk_en <= 1'b0;
        if (mid_pulse) begin
            repeat (20) @(posedge clk);
            sample_clk_en <= 1'b1;
            @(posedge clk);
            sample_clk_en <= 1'b0;
        end
        while (done_count == done_start)
            @(posedge clk);
        check_count("records per pass", rec_count - rec_start, NUM_SLOTS);
        passes_run++;
    endtask

    // compare process
    always @(posedge clk) begin
        if (!reset) begin
            check_flag("ops_done_pulse", ops_done_pulse, prev_final);
            prev_final = 1'b0;
            if (op_out_valid) begin
                exp_val = expected_value(exp_idx / NUM_OPS_PER_BANK, exp_idx % NUM_OPS_PER_BANK);
                check_slot(op_out_bank, op_out_op_num, BANK_W'(exp_idx / NUM_OPS_PER_BANK),
                           OP_NUM_W'(exp_idx % NUM_OPS_PER_BANK));
                check_value(op_out_value, exp_val);
                prev_final = exp_idx == NUM_SLOTS - 1;
                exp_idx    = (exp_idx + 1) % NUM_SLOTS;
                rec_count <= rec_count + 1;
            end
            if (ops_done_pulse)
                done_count <= done_count + 1;
            if (UUT.u_sva.failures != 0)
                fail_run("a bound timing assertion failed");
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES)
            fail_run($sformatf("timeout after %0d cycles, a pass never finished", cycle_count));
    end

    initial begin
        void'($urandom(32'h881e));
        reset          = 1'b1;
        sample_clk_en  = 1'b0;
        reg_wr_valid   = 1'b0;
        reg_wr_bank    = '0;
        reg_wr_address = '0;
        reg_wr_data    = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int op = 0; op < NUM_OPS_PER_BANK; op++)
                mult_m[b][op] = 0;
            for (int ch = 0; ch < NUM_CHANNELS_PER_BANK; ch++) begin
                fnum_m[b][ch]  = 0;
                block_m[b][ch] = 0;
                kon_m[b][ch]   = 0;
                cnt_m[b][ch]   = 0;
                mod_m[b][ch]   = '0;
            end
        end
        for (int s = 0; s < NUM_SLOTS; s++)
            model_phase[s] = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        repeat (50) begin // idle, no pulse
            @(posedge clk);
            check_flag("op_out_valid", op_out_valid, 1'b0);
        end

        run_pass(1'b1); // extra pulse mid-pass must be dropped
        repeat (10) @(posedge clk);
        check_count("records after one pass", rec_count, NUM_SLOTS);
        check_count("ops_done_pulse count", done_count, 1);

        randomize_voices();
        for (int b = 0; b < NUM_BANKS; b++)
            for (int ch = 0; ch < NUM_CHANNELS_PER_BANK; ch++)
                set_cnt(b, ch, 1);
        repeat (8) run_pass(1'b0);

        for (int b = 0; b < NUM_BANKS; b++)
            for (int ch = 0; ch < NUM_CHANNELS_PER_BANK; ch++)
                set_cnt(b, ch, $urandom % 2); // FM on a random subset
        repeat (4) run_pass(1'b0);

        set_freq(0, 4, fnum_m[0][4], block_m[0][4], 0);
        set_freq(1, 8, fnum_m[1][8], block_m[1][8], 0);
        run_pass(1'b0);
        set_freq(0, 4, fnum_m[0][4], block_m[0][4], 1);
        set_freq(1, 8, fnum_m[1][8], block_m[1][8], 1);
        run_pass(1'b0);
        for (int b = 0; b < NUM_BANKS; b++) begin
            reg_write(b, 'h26, $urandom % 256); // unused operator offsets
            reg_write(b, 'h27, $urandom % 256);
            reg_write(b, 'h2E, $urandom % 256);
            reg_write(b, 'h2F, $urandom % 256);
        end
        run_pass(1'b0);

        repeat (10) @(posedge clk);
        if (rec_count == passes_run * NUM_SLOTS && done_count == passes_run) begin
            $display("TEST OK");
            $finish;
        end else begin
            fail_run($sformatf("totals off at end: %0d records, %0d done pulses, %0d passes",
                               rec_count, done_count, passes_run));
        end
    end

endmodule

//--- tests/tb_clock.sv
// free-running testbench clock, 8 ns period, starts low at time 0
`timescale 1ns/100ps

module tb_clock #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk; // half period per phase
    end

endmodule

//--- verilog/modulation_router.sv
// two-operator routing only; a carrier reads its modulator's latest output, which lands 3 cycles early
`timescale 1ns/100ps

module modulation_router
    import opl_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic [BANK_W-1:0]   issue_bank,
    input  logic [OP_NUM_W-1:0] issue_op_num,
    input  logic                cnt,
    input  logic                out_valid,
    input  logic [BANK_W-1:0]   out_bank,
    input  logic [OP_NUM_W-1:0] out_op_num,
    input  op_out_t             out_value,
    output op_out_t             modulation
);
    op_out_t mod_store [NUM_BANKS][NUM_CHANNELS_PER_BANK];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < NUM_BANKS; b++)
                for (int c = 0; c < NUM_CHANNELS_PER_BANK; c++)
                    mod_store[b][c] <= '0;
        end else if (out_valid && is_modulator(out_op_num)) begin
            mod_store[out_bank][op_to_chan(out_op_num)] <= out_value;
        end
    end

    // cnt = 1 means additive, so the carrier runs unmodulated
    always_comb begin
        if (is_modulator(issue_op_num) || cnt)
            modulation = '0;
        else
            modulation = mod_store[issue_bank][op_to_chan(issue_op_num)];
    end

endmodule

//--- verilog/operator_control.sv
// top level; slot k issues 1 + 2k cycles after the start pulse, output 3 cycles after issue, no back-pressure
`timescale 1ns/100ps

module operator_control
    import opl_ctrl_pkg::*;
#(
    parameter int NUM_BANKS = opl_ctrl_pkg::NUM_BANKS,
    parameter int PHASE_W   = opl_ctrl_pkg::PHASE_W
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  sample_clk_en,
    input  logic                  reg_wr_valid,
    input  logic [BANK_W-1:0]     reg_wr_bank,
    input  logic [REG_ADDR_W-1:0] reg_wr_address,
    input  logic [REG_DATA_W-1:0] reg_wr_data,
    output logic                  op_out_valid,
    output logic [BANK_W-1:0]     op_out_bank,
    output logic [OP_NUM_W-1:0]   op_out_op_num,
    output op_out_t               op_out_value,
    output logic                  ops_done_pulse
);
    logic                issue;
    logic [BANK_W-1:0]   issue_bank;
    logic [OP_NUM_W-1:0] issue_op_num;
    logic [MULT_W-1:0]   mult;
    logic [FNUM_W-1:0]   fnum;
    logic [BLOCK_W-1:0]  block;
    logic                kon;
    logic                cnt;
    op_out_t             modulation;
    logic                out_valid;
    logic [BANK_W-1:0]   out_bank;
    logic [OP_NUM_W-1:0] out_op_num;
    op_out_t             out_value;

    slot_sequencer #(.NUM_BANKS(NUM_BANKS)) u_seq (
        .clk, .reset, .sample_clk_en, .issue, .issue_bank, .issue_op_num
    );

    slot_registers u_regs (
        .clk, .reset, .reg_wr_valid, .reg_wr_bank, .reg_wr_address, .reg_wr_data,
        .issue_bank, .issue_op_num, .mult, .fnum, .block, .kon, .cnt
    );

    phase_generator #(.NUM_BANKS(NUM_BANKS), .PHASE_W(PHASE_W)) u_pg (
        .clk, .reset, .issue, .issue_bank, .issue_op_num, .mult, .fnum, .block, .kon,
        .modulation, .out_valid, .out_bank, .out_op_num, .out_value
    );

    modulation_router u_mod (
        .clk, .reset, .issue_bank, .issue_op_num, .cnt,
        .out_valid, .out_bank, .out_op_num, .out_value, .modulation
    );

    operator_output #(.NUM_BANKS(NUM_BANKS)) u_out (
        .clk, .reset, .out_valid, .out_bank, .out_op_num, .out_value,
        .op_out_valid, .op_out_bank, .op_out_op_num, .op_out_value, .ops_done_pulse
    );

endmodule

//--- verilog/operator_output.sv
// record passes straight through; ops_done_pulse lands one cycle after the last slot's record
`timescale 1ns/100ps

module operator_output
    import opl_ctrl_pkg::*;
#(
    parameter int NUM_BANKS = 2
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                out_valid,
    input  logic [BANK_W-1:0]   out_bank,
    input  logic [OP_NUM_W-1:0] out_op_num,
    input  op_out_t             out_value,
    output logic                op_out_valid,
    output logic [BANK_W-1:0]   op_out_bank,
    output logic [OP_NUM_W-1:0] op_out_op_num,
    output op_out_t             op_out_value,
    output logic                ops_done_pulse
);
    assign op_out_valid  = out_valid;
    assign op_out_bank   = out_bank;
    assign op_out_op_num = out_op_num;
    assign op_out_value  = out_value;

    always_ff @(posedge clk) begin
        if (reset)
            ops_done_pulse <= 1'b0;
        else
            ops_done_pulse <= out_valid && out_bank == BANK_W'(NUM_BANKS - 1)
                              && out_op_num == OP_NUM_W'(NUM_OPS_PER_BANK - 1); // last slot
    end

endmodule

//--- verilog/opl_ctrl_pkg.sv
// two-operator FM only: no envelope, rhythm, feedback or four-op support; include/ must be on the path
package opl_ctrl_pkg;

    `include "opl_ctrl_defs.svh"

    localparam int NUM_BANKS             = 2;
    localparam int NUM_OPS_PER_BANK      = 18;
    localparam int NUM_SLOTS             = NUM_BANKS * NUM_OPS_PER_BANK;
    localparam int NUM_CHANNELS_PER_BANK = 9;

    localparam int BANK_W     = 1;
    localparam int OP_NUM_W   = 5;
    localparam int CHAN_W     = 4;
    localparam int REG_ADDR_W = 8;
    localparam int REG_DATA_W = 8;
    localparam int FNUM_W     = 10;
    localparam int BLOCK_W    = 3;
    localparam int MULT_W     = 4;
    localparam int PHASE_W    = 19;
    localparam int OP_OUT_W   = 13;

    typedef logic signed [OP_OUT_W-1:0] op_out_t;

    // twice the frequency multiple, so 0.5x stays an integer
    localparam logic [4:0] MULT_X2 [16] = '{
        5'd1, 5'd2, 5'd4, 5'd6, 5'd8, 5'd10, 5'd12, 5'd14,
        5'd16, 5'd18, 5'd20, 5'd20, 5'd24, 5'd24, 5'd30, 5'd30
    };

    typedef enum logic [1:0] {SEQ_IDLE, SEQ_ISSUE, SEQ_HOLD} seq_state_t;

    // ops 0-5 -> ch 0-2, 6-11 -> ch 3-5, 12-17 -> ch 6-8
    function automatic logic [CHAN_W-1:0] op_to_chan(input logic [OP_NUM_W-1:0] op);
        if (op < 6)
            return CHAN_W'(op % 3);
        else if (op < 12)
            return CHAN_W'(3 + op % 3);
        return CHAN_W'(6 + op % 3);
    endfunction

    function automatic logic is_modulator(input logic [OP_NUM_W-1:0] op);
        return (op % 6) < 3; // first three of each group of six
    endfunction

endpackage

//--- verilog/phase_generator.sv
// 3-stage phase pipeline; output is the signed phase top plus modulation, no sine lookup; PHASE_W >= 13
`timescale 1ns/100ps

module phase_generator
    import opl_ctrl_pkg::*;
#(
    parameter int NUM_BANKS = 2,
    parameter int PHASE_W   = 19
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                issue,
    input  logic [BANK_W-1:0]   issue_bank,
    input  logic [OP_NUM_W-1:0] issue_op_num,
    input  logic [MULT_W-1:0]   mult,
    input  logic [FNUM_W-1:0]   fnum,
    input  logic [BLOCK_W-1:0]  block,
    input  logic                kon,
    input  op_out_t             modulation,
    output logic                out_valid,
    output logic [BANK_W-1:0]   out_bank,
    output logic [OP_NUM_W-1:0] out_op_num,
    output op_out_t             out_value
);
    localparam int DEPTH  = NUM_BANKS * NUM_OPS_PER_BANK;
    localparam int SLOT_W = $clog2(DEPTH);
    localparam int INC_W  = FNUM_W + 2 ** BLOCK_W - 1 + 5; // fnum << 7, times up to 30

    logic [PHASE_W-1:0] phase_mem [DEPTH];
    logic [SLOT_W-1:0]  issue_slot;

    logic                valid_p1, valid_p2;
    logic [SLOT_W-1:0]   slot_p1;
    logic [BANK_W-1:0]   bank_p1, bank_p2;
    logic [OP_NUM_W-1:0] op_p1, op_p2;
    logic [MULT_W-1:0]   mult_p1;
    logic [FNUM_W-1:0]   fnum_p1;
    logic [BLOCK_W-1:0]  block_p1;
    logic                kon_p1, kon_p2;
    op_out_t             mod_p1, mod_p2;
    logic [PHASE_W-1:0]  phase_p1, phase_p2;
    logic [INC_W-1:0]    inc;
    logic [PHASE_W-1:0]  new_phase;

    assign issue_slot = SLOT_W'(int'(issue_bank) * NUM_OPS_PER_BANK + int'(issue_op_num));

    always_comb begin
        inc       = ((INC_W'(fnum_p1) << block_p1) * INC_W'(MULT_X2[mult_p1])) >> 2;
        new_phase = kon_p1 ? phase_p1 + PHASE_W'(inc) : '0; // key-off restarts from 0
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_p1  <= 1'b0;
            valid_p2  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_p1  <= issue;
            valid_p2  <= valid_p1;
            out_valid <= valid_p2;
        end
    end

    always_ff @(posedge clk) begin
        slot_p1  <= issue_slot; // stage 1
        bank_p1  <= issue_bank;
        op_p1    <= issue_op_num;
        mult_p1  <= mult;
        fnum_p1  <= fnum;
        block_p1 <= block;
        kon_p1   <= kon;
        mod_p1   <= modulation;
        phase_p1 <= phase_mem[issue_slot];
        bank_p2  <= bank_p1; // stage 2
        op_p2    <= op_p1;
        kon_p2   <= kon_p1;
        mod_p2   <= mod_p1;
        phase_p2 <= new_phase;
        out_bank   <= bank_p2; // stage 3
        out_op_num <= op_p2;
        out_value  <= kon_p2 ? $signed(phase_p2[PHASE_W-1 -: OP_OUT_W]) + mod_p2 : '0;
    end

    // phase memory, written back in stage 2
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++)
                phase_mem[i] <= '0;
        end else if (valid_p1) begin
            phase_mem[slot_p1] <= new_phase;
        end
    end

endmodule

//--- verilog/slot_registers.sv
// register file for mult, fnum, block, kon and cnt only; other addresses are ignored, reads are combinational
`timescale 1ns/100ps

module slot_registers
    import opl_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  reg_wr_valid,
    input  logic [BANK_W-1:0]     reg_wr_bank,
    input  logic [REG_ADDR_W-1:0] reg_wr_address,
    input  logic [REG_DATA_W-1:0] reg_wr_data,
    input  logic [BANK_W-1:0]     issue_bank,
    input  logic [OP_NUM_W-1:0]   issue_op_num,
    output logic [MULT_W-1:0]     mult,
    output logic [FNUM_W-1:0]     fnum,
    output logic [BLOCK_W-1:0]    block,
    output logic                  kon,
    output logic                  cnt
);
    logic [MULT_W-1:0]  mult_mem  [NUM_BANKS][NUM_OPS_PER_BANK];
    logic [FNUM_W-1:0]  fnum_mem  [NUM_BANKS][NUM_CHANNELS_PER_BANK];
    logic [BLOCK_W-1:0] block_mem [NUM_BANKS][NUM_CHANNELS_PER_BANK];
    logic               kon_mem   [NUM_BANKS][NUM_CHANNELS_PER_BANK];
    logic               cnt_mem   [NUM_BANKS][NUM_CHANNELS_PER_BANK];

    logic [4:0]          wr_offset;
    logic [OP_NUM_W-1:0] wr_op;
    logic                op_wr;
    logic [CHAN_W-1:0]   wr_chan;
    logic                chan_ok;
    logic [CHAN_W-1:0]   rd_chan;

    always_comb begin
        wr_offset = reg_wr_address[4:0];
        wr_op     = OP_NUM_W'(wr_offset[4:3] * 6 + wr_offset[2:0]); // groups of 8 offsets, 6 used
        op_wr     = reg_wr_valid && reg_wr_address >= 8'h20 && reg_wr_address <= 8'h35
                    && wr_offset[2:0] < 3'd6; // skips offsets 6, 7, 14, 15
        wr_chan   = reg_wr_address[CHAN_W-1:0];
        chan_ok   = reg_wr_valid && wr_chan < NUM_CHANNELS_PER_BANK;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int o = 0; o < NUM_OPS_PER_BANK; o++)
                    mult_mem[b][o] <= '0;
                for (int c = 0; c < NUM_CHANNELS_PER_BANK; c++) begin
                    fnum_mem[b][c]  <= '0;
                    block_mem[b][c] <= '0;
                    kon_mem[b][c]   <= 1'b0;
                    cnt_mem[b][c]   <= 1'b0;
                end
            end
        end else begin
            if (op_wr)
                mult_mem[reg_wr_bank][wr_op] <= reg_wr_data[MULT_W-1:0];
            if (chan_ok && reg_wr_address[7:4] == 4'hA)
                fnum_mem[reg_wr_bank][wr_chan][7:0] <= reg_wr_data; // fnum low byte
            if (chan_ok && reg_wr_address[7:4] == 4'hB) begin
                kon_mem[reg_wr_bank][wr_chan]       <= reg_wr_data[5];
                block_mem[reg_wr_bank][wr_chan]     <= reg_wr_data[4:2];
                fnum_mem[reg_wr_bank][wr_chan][9:8] <= reg_wr_data[1:0];
            end
            if (chan_ok && reg_wr_address[7:4] == 4'hC)
                cnt_mem[reg_wr_bank][wr_chan] <= reg_wr_data[0];
        end
    end

    assign rd_chan = op_to_chan(issue_op_num);
    assign mult    = mult_mem[issue_bank][issue_op_num];
    assign fnum    = fnum_mem[issue_bank][rd_chan];
    assign block   = block_mem[issue_bank][rd_chan];
    assign kon     = kon_mem[issue_bank][rd_chan];
    assign cnt     = cnt_mem[issue_bank][rd_chan];

endmodule

//--- verilog/slot_sequencer.sv
// one pass per sample_clk_en pulse, slots in bank-major order; pulses during a pass are dropped
`timescale 1ns/100ps

module slot_sequencer
    import opl_ctrl_pkg::*;
#(
    parameter int NUM_BANKS = 2
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                sample_clk_en,
    output logic                issue,
    output logic [BANK_W-1:0]   issue_bank,
    output logic [OP_NUM_W-1:0] issue_op_num
);
    seq_state_t state;
    logic       last_slot;

    assign last_slot = issue_bank == BANK_W'(NUM_BANKS - 1)
                       && issue_op_num == OP_NUM_W'(NUM_OPS_PER_BANK - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= SEQ_IDLE;
            issue_bank   <= '0;
            issue_op_num <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (sample_clk_en)
                        state <= SEQ_ISSUE;
                end
                SEQ_ISSUE: state <= SEQ_HOLD;
                SEQ_HOLD: begin
                    if (last_slot) begin
                        state        <= SEQ_IDLE;
                        issue_bank   <= '0; // ready for next pass
                        issue_op_num <= '0;
                    end else begin
                        state <= SEQ_ISSUE;
                        if (issue_op_num == OP_NUM_W'(NUM_OPS_PER_BANK - 1)) begin
                            issue_op_num <= '0;
                            issue_bank   <= issue_bank + 1'b1;
                        end else begin
                            issue_op_num <= issue_op_num + 1'b1;
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    assign issue = state == SEQ_ISSUE;

endmodule
